// File: all.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/arm_core.sv
testbench/arm_core_properties.sv
testbench/arm_core_tb.sv

// File: Bender.yml
package:
  name: arm_core

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/pipe_pkg.sv
      - rtl/reg_file.sv
      - rtl/fetch_stage.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/arm_core.sv
  - target: test
    files:
      - testbench/arm_core_properties.sv
      - testbench/arm_core_tb.sv

// File: testbench/arm_core_tb.sv
`timescale 1ns/100ps

module arm_core_tb;
    import isa_pkg::*;

    localparam int mem_words      = 128;
    localparam int drive_delay    = 1;
    localparam int retire_timeout = 20;
    localparam int drain_cycles   = 4;

    logic     clk;
    logic     reset;
    word_t    pc;
    instr_t   instr;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;

    integer   seed;
    instr_t   mem [mem_words];
    string    test_of [mem_words];
    int       prog_len;
    string    cur_test;
    word_t    model_regs [16];

    // expected retirements in program order
    reg_idx_t exp_reg_q [$];
    word_t    exp_data_q [$];
    string    exp_test_q [$];
    reg_idx_t exp_reg;
    word_t    exp_data;
    string    exp_test;

    arm_core arm_core_i (
        .clk     (clk),
        .reset   (reset),
        .pc      (pc),
        .instr   (instr),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // failure reporting
    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_value_error(string test, string expected, string actual);
        $display("Error: test %s, expected %s, actual %s", test, expected, actual);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // program memory
    // op field 01 decodes as neither data processing nor branch
    function automatic instr_t fill_word(word_t addr);
        logic [29:0] fold;
        fold = addr[31:2] ^ (addr[31:2] >> 13);
        return {6'b000001, fold[25:0]};
    endfunction

    function automatic instr_t word_at(word_t addr);
        if (addr[31:2] < mem_words) begin
            return mem[addr[8:2]];
        end
        return fill_word(addr);
    endfunction

    always @(posedge clk) begin
        #drive_delay;
        instr = word_at(pc);
    end

    //////////////////////////////////////////////////////////////////////
    // encoders and program build
    function automatic instr_t enc_dp_imm(alu_op_e cmd, reg_idx_t rd, reg_idx_t rn,
                                          logic [7:0] imm8);
        return {4'he, 2'b00, 1'b1, cmd, 1'b0, rn, rd, 4'h0, imm8};
    endfunction

    function automatic instr_t enc_dp_reg(alu_op_e cmd, reg_idx_t rd, reg_idx_t rn,
                                          reg_idx_t rm, shift_e sh, logic [4:0] shamt);
        return {4'he, 2'b00, 1'b0, cmd, 1'b0, rn, rd, shamt, sh, 1'b0, rm};
    endfunction

    // target is own address plus 8 plus offset words
    function automatic instr_t enc_branch(int offset);
        logic [23:0] off24;
        off24 = offset[23:0];
        return {4'he, 4'b1010, off24};
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'(rand_below(15));
    endfunction

    task automatic put_instr(instr_t w);
        mem[prog_len] = w;
        test_of[prog_len] = cur_test;
        prog_len++;
    endtask

    task automatic build_program();
        alu_op_e  cmds [4];
        reg_idx_t prev;
        reg_idx_t rd;
        cmds = '{alu_add, alu_sub, alu_and, alu_orr};
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = fill_word(word_t'(i * 4));
            test_of[i] = "fill";
        end
        prog_len = 0;

        cur_test = "imm_ops";
        for (int i = 0; i < 16; i++) begin
            put_instr(enc_dp_imm(cmds[i % 4], rand_reg(), rand_reg(), 8'(rand_below(256))));
        end

        cur_test = "shift_ops";
        for (int i = 0; i < 16; i++) begin
            put_instr(enc_dp_reg(cmds[rand_below(4)], rand_reg(), rand_reg(), rand_reg(),
                                 shift_e'(i % 4), 5'(rand_below(32))));
        end

        // each op reads the result retiring just ahead of it
        cur_test = "bypass";
        prev = rand_reg();
        put_instr(enc_dp_imm(alu_add, prev, prev, 8'(rand_below(256))));
        for (int i = 0; i < 8; i++) begin
            rd = rand_reg();
            if (i % 2 == 0) begin
                put_instr(enc_dp_imm(cmds[i % 4], rd, prev, 8'(rand_below(256))));
            end else begin
                put_instr(enc_dp_reg(cmds[i % 4], rd, prev, prev,
                                     shift_e'(rand_below(4)), 5'(rand_below(32))));
            end
            prev = rd;
        end

        cur_test = "branch_fwd";
        put_instr(enc_branch(1));
        put_instr(enc_dp_imm(alu_add, 4'd1, 4'd1, 8'd1));
        put_instr(enc_dp_imm(alu_orr, 4'd2, 4'd2, 8'hff));
        put_instr(enc_dp_imm(alu_add, 4'd3, 4'd3, 8'(rand_below(256))));

        // forward over the body, back into it once and then out
        cur_test = "branch_loop";
        put_instr(enc_branch(2));
        put_instr(enc_dp_imm(alu_add, 4'd4, 4'd4, 8'(rand_below(256))));
        put_instr(enc_branch(4));
        put_instr(enc_dp_imm(alu_add, 4'd5, 4'd5, 8'd5));
        put_instr(enc_dp_imm(alu_add, 4'd6, 4'd6, 8'(rand_below(256))));
        put_instr(enc_branch(-6));
        put_instr(enc_dp_imm(alu_add, 4'd7, 4'd7, 8'd7));
        put_instr(enc_dp_imm(alu_add, 4'd8, 4'd8, 8'd8));
        put_instr(enc_dp_imm(alu_add, 4'd9, 4'd9, 8'(rand_below(256))));

        cur_test = "r15_read";
        put_instr(enc_dp_imm(alu_add, rand_reg(), pc_reg, 8'(rand_below(256))));
        put_instr(enc_dp_reg(alu_add, rand_reg(), rand_reg(), pc_reg, sh_lsl, 5'd0));

        // r15 destination, register shift amount and eor
        cur_test = "no_write";
        put_instr(enc_dp_imm(alu_add, pc_reg, rand_reg(), 8'(rand_below(256))));
        put_instr(enc_dp_reg(alu_add, rand_reg(), rand_reg(), rand_reg(), sh_lsl, 5'd0)
                  | 32'h0000_0010);
        put_instr({4'he, 3'b001, 4'b0001, 1'b0, 4'd1, 4'd2, 12'h0ff});
        put_instr(enc_dp_imm(alu_orr, rand_reg(), rand_reg(), 8'(rand_below(256))));
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    function automatic word_t model_read(reg_idx_t r, word_t addr);
        return (r == 4'd15) ? addr + 32'd8 : model_regs[r];
    endfunction

    function automatic word_t shift_value(word_t v, logic [1:0] sh, logic [4:0] n);
        word_t sign_fill;
        sign_fill = v[31] ? ~(32'hffff_ffff >> n) : 32'h0;
        case (sh)
            2'b00: return v << n;
            2'b01: return v >> n;
            2'b10: return (v >> n) | sign_fill;
            default: return (n == 0) ? v : (v >> n) | (v << (6'd32 - n));
        endcase
    endfunction

    task automatic model_dp(instr_t w, word_t addr);
        word_t    a;
        word_t    b;
        word_t    result;
        reg_idx_t rd;
        logic     writes;
        rd = w[15:12];
        a = model_read(w[19:16], addr);
        b = w[25] ? {24'h0, w[7:0]} : shift_value(model_read(w[3:0], addr), w[6:5], w[11:7]);
        writes = (rd != 4'd15) && (w[25] || !w[4]);
        result = '0;
        case (w[24:21])
            4'b0100: result = a + b;
            4'b0010: result = a - b;
            4'b0000: result = a & b;
            4'b1100: result = a | b;
            default: writes = 1'b0;
        endcase
        if (writes) begin
            model_regs[rd] = result;
            exp_reg_q.push_back(rd);
            exp_data_q.push_back(result);
            exp_test_q.push_back(test_of[addr[8:2]]);
        end
    endtask

    task automatic run_model();
        word_t  addr;
        instr_t w;
        int     steps;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        addr = '0;
        steps = 0;
        while (addr < prog_len * 4 && steps < 1000) begin
            w = mem[addr[8:2]];
            steps++;
            if (w[27:26] == 2'b10) begin
                addr = addr + 32'd8 + {{6{w[23]}}, w[23:0], 2'b00};
            end else begin
                if (w[27:26] == 2'b00) begin
                    model_dp(w, addr);
                end
                addr = addr + 32'd4;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (arm_core_i.arm_core_properties_i.violations != 0) begin
            stop_with_failure("a bound property of the core failed");
        end else if (!reset && wb_en) begin
            if (exp_reg_q.size() == 0) begin
                stop_with_failure("a register write retired when none was expected");
            end else begin
                exp_reg = exp_reg_q.pop_front();
                exp_data = exp_data_q.pop_front();
                exp_test = exp_test_q.pop_front();
                assert (wb_reg == exp_reg && wb_data == exp_data) else begin
                    report_value_error(exp_test,
                                       $sformatf("r%0d = 0x%08h", exp_reg, exp_data),
                                       $sformatf("r%0d = 0x%08h", wb_reg, wb_data));
                end
            end
        end
    end

    task automatic check_pc_steps();
        word_t exp_pc;
        for (int k = 0; k < 4; k++) begin
            exp_pc = word_t'(k * 4);
            assert (pc == exp_pc) else begin
                report_value_error("reset", $sformatf("pc = 0x%08h", exp_pc),
                                   $sformatf("pc = 0x%08h", pc));
            end
            @(posedge clk);
            #drive_delay;
        end
    endtask

    task automatic wait_for_retirements();
        int left;
        int cycles;
        while (exp_reg_q.size() != 0) begin
            left = exp_reg_q.size();
            cycles = 0;
            while (exp_reg_q.size() == left && cycles < retire_timeout) begin
                @(posedge clk);
                cycles++;
            end
            if (exp_reg_q.size() == left) begin
                stop_with_failure($sformatf("no retirement came within %0d cycles, %0d pending",
                                            retire_timeout, left));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        seed = 32'hc1a3e84e;
        reset = 1'b0;
        instr = fill_word('0);
        build_program();
        run_model();
        #drive_delay;
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        check_pc_steps();
        wait_for_retirements();
        // shadows and fill words must not retire
        repeat (drain_cycles) @(posedge clk);
        #drive_delay;
        if (arm_core_i.arm_core_properties_i.violations == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_with_failure("a bound property of the core failed");
        end
    end

endmodule

// File: testbench/arm_core_properties.sv
`timescale 1ns/100ps

module arm_core_properties (
    input logic              clk,
    input logic              reset,
    input isa_pkg::word_t    pc,
    input logic              wb_en,
    input isa_pkg::reg_idx_t wb_reg
);
    import isa_pkg::*;

    // failed property count
    int violations = 0;

    // reset vector held, nothing retires
    reset_state: assert property (@(posedge clk) reset |-> (pc == '0 && !wb_en))
        else begin
            violations++;
            $error("pc is not zero or wb_en is high while reset is high");
        end

    pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
        else begin
            violations++;
            $error("pc is not word aligned");
        end

    // r15 is never a destination
    no_pc_write: assert property (@(posedge clk) disable iff (reset) wb_en |-> wb_reg != pc_reg)
        else begin
            violations++;
            $error("a retirement targets r15");
        end

    wb_en_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(wb_en))
        else begin
            violations++;
            $error("wb_en is unknown out of reset");
        end

endmodule

bind arm_core arm_core_properties arm_core_properties_i (
    .clk    (clk),
    .reset  (reset),
    .pc     (pc),
    .wb_en  (wb_en),
    .wb_reg (wb_reg)
);

// File: rtl/arm_core.sv
`timescale 1ns/100ps

module arm_core (
    input  logic              clk,
    input  logic              reset,
    output isa_pkg::word_t    pc,
    input  isa_pkg::instr_t   instr,
    output logic              wb_en,
    output isa_pkg::reg_idx_t wb_reg,
    output isa_pkg::word_t    wb_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_slot_t slot;
    exec_op_t    op;
    logic        redirect;
    word_t       redirect_pc;

    // fetch
    fetch_stage fetch_stage_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .slot        (slot)
    );

    // decode and register read
    decode_stage decode_stage_i (
        .clk      (clk),
        .reset    (reset),
        .slot     (slot),
        .redirect (redirect),
        .wb_en    (wb_en),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .op       (op)
    );

    // execute and writeback
    execute_stage execute_stage_i (
        .clk         (clk),
        .reset       (reset),
        .op          (op),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data)
    );

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  pipe_pkg::exec_op_t op,
    output logic               redirect,
    output isa_pkg::word_t     redirect_pc,
    output logic               wb_en,
    output isa_pkg::reg_idx_t  wb_reg,
    output isa_pkg::word_t     wb_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    exec_op_t op_q;
    word_t    shifted_b;
    word_t    src_b;
    word_t    alu_result;

    //////////////////////////////////////////////////////////////////////
    // execute register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_q <= '0;
        end else begin
            op_q <= op;
            // taken branch kills the op behind it
            if (redirect) begin
                op_q.valid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // barrel shifter
    // amount 0 passes b through for every shift type
    always_comb begin
        case (op_q.shift)
            sh_lsl: shifted_b = op_q.b << op_q.shamt;
            sh_lsr: shifted_b = op_q.b >> op_q.shamt;
            sh_asr: shifted_b = word_t'($signed(op_q.b) >>> op_q.shamt);
            default: begin
                // ror, low half of the doubled word
                shifted_b = word_t'({op_q.b, op_q.b} >> op_q.shamt);
            end
        endcase
    end

    assign src_b = op_q.shifted ? shifted_b : op_q.b;

    //////////////////////////////////////////////////////////////////////
    // alu
    always_comb begin
        case (op_q.alu_op)
            alu_and: alu_result = op_q.a & src_b;
            alu_sub: alu_result = op_q.a - src_b;
            alu_add: alu_result = op_q.a + src_b;
            alu_orr: alu_result = op_q.a | src_b;
            // other cmds never write
            default: alu_result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // retire and branch
    assign redirect    = op_q.valid && op_q.branch;
    assign redirect_pc = op_q.target;

    assign wb_en   = op_q.valid && op_q.we;
    assign wb_reg  = op_q.rd;
    assign wb_data = alu_result;

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  pipe_pkg::fetch_slot_t slot,
    input  logic                  redirect,
    input  logic                  wb_en,
    input  isa_pkg::reg_idx_t     wb_reg,
    input  isa_pkg::word_t        wb_data,
    output pipe_pkg::exec_op_t    op
);
    import isa_pkg::*;
    import pipe_pkg::*;

    op_e                  opcode;
    logic                 imm_form;
    logic [3:0]           cmd;
    reg_idx_t             rn;
    reg_idx_t             rd;
    reg_idx_t             rm;
    logic [4:0]           shamt;
    shift_e               sh;
    logic                 shift_by_reg;
    logic [imm8_msb:0]    imm8;
    logic [imm24_msb:0]   imm24;

    word_t                rn_val;
    word_t                rm_val;
    word_t                r15_val;
    word_t                branch_offset;

    logic                 is_dp;
    logic                 is_branch;
    logic                 cmd_ok;
    logic                 dp_write;

    //////////////////////////////////////////////////////////////////////
    // fields
    assign opcode       = op_e'(slot.instr[op_msb:op_lsb]);
    assign imm_form     = slot.instr[i_bit];
    assign cmd          = slot.instr[cmd_msb:cmd_lsb];
    assign rn           = slot.instr[rn_msb:rn_lsb];
    assign rd           = slot.instr[rd_msb:rd_lsb];
    assign rm           = slot.instr[rm_msb:rm_lsb];
    assign shamt        = slot.instr[shamt_msb:shamt_lsb];
    assign sh           = shift_e'(slot.instr[sh_msb:sh_lsb]);
    assign shift_by_reg = slot.instr[shreg_bit];
    assign imm8         = slot.instr[imm8_msb:0];
    assign imm24        = slot.instr[imm24_msb:0];

    //////////////////////////////////////////////////////////////////////
    // register read
    // r15 is this instruction's address plus 8
    assign r15_val = slot.addr + pc_read_offset;

    reg_file reg_file_i (
        .clk   (clk),
        .reset (reset),
        .ra1   (rn),
        .ra2   (rm),
        .rd1   (rn_val),
        .rd2   (rm_val),
        .we    (wb_en),
        .wa    (wb_reg),
        .wd    (wb_data),
        .r15   (r15_val)
    );

    //////////////////////////////////////////////////////////////////////
    // control
    assign is_dp     = (opcode == op_dp);
    assign is_branch = (opcode == op_branch);
    assign cmd_ok    = cmd inside {alu_and, alu_sub, alu_add, alu_orr};

    // no pc writes, no register-specified shifts
    assign dp_write = is_dp && cmd_ok && (rd != pc_reg) && (imm_form || !shift_by_reg);

    // word offset, sign extended
    assign branch_offset = {{6{imm24[imm24_msb]}}, imm24, 2'b00};

    always_comb begin
        // wrong-path slot is dropped here
        op.valid   = slot.valid && !redirect;
        op.alu_op  = alu_op_e'(cmd);
        op.shift   = sh;
        op.shamt   = shamt;
        op.shifted = !imm_form;
        op.a       = rn_val;
        // imm8 zero extended, no rotate
        op.b       = imm_form ? word_t'(imm8) : rm_val;
        op.rd      = rd;
        op.we      = dp_write;
        op.branch  = is_branch;
        op.target  = r15_val + branch_offset;
    end

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  isa_pkg::instr_t       instr,
    input  logic                  redirect,
    input  isa_pkg::word_t        redirect_pc,
    output isa_pkg::word_t        pc,
    output pipe_pkg::fetch_slot_t slot
);
    import isa_pkg::*;
    import pipe_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // program counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else begin
            pc <= pc + pc_step;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction slot
    // instr belongs to the current pc, so the slot takes both together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot <= '0;
        end else if (redirect) begin
            // word at pc is on the wrong path
            slot.valid <= 1'b0;
        end else begin
            slot.valid <= 1'b1;
            slot.instr <= instr;
            slot.addr  <= pc;
        end
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::reg_idx_t ra1,
    input  isa_pkg::reg_idx_t ra2,
    output isa_pkg::word_t    rd1,
    output isa_pkg::word_t    rd2,
    input  logic              we,
    input  isa_pkg::reg_idx_t wa,
    input  isa_pkg::word_t    wd,
    input  isa_pkg::word_t    r15
);
    import isa_pkg::*;

    // r0..r14, r15 lives in the fetch path
    word_t regs [num_regs];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != pc_reg) begin
            regs[wa] <= wd;
        end
    end

    // write-first, the retiring result bypasses to decode
    assign rd1 = (ra1 == pc_reg)        ? r15 :
                 (we && ra1 == wa)      ? wd  :
                                          regs[ra1];

    assign rd2 = (ra2 == pc_reg)        ? r15 :
                 (we && ra2 == wa)      ? wd  :
                                          regs[ra2];

endmodule

// File: rtl/pipe_pkg.sv
package pipe_pkg;

    //////////////////////////////////////////////////////////////////////
    // fetch to decode
    typedef struct packed {
        logic            valid;
        isa_pkg::instr_t instr;
        // address of instr, for r15 reads and branch targets
        isa_pkg::word_t  addr;
    } fetch_slot_t;

    //////////////////////////////////////////////////////////////////////
    // decode to execute
    typedef struct packed {
        logic              valid;
        isa_pkg::alu_op_e  alu_op;
        isa_pkg::shift_e   shift;
        logic [4:0]        shamt;
        // b came from rm and goes through the shifter
        logic              shifted;
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
        isa_pkg::reg_idx_t rd;
        logic              we;
        logic              branch;
        isa_pkg::word_t    target;
    } exec_op_t;

endpackage

// File: rtl/isa_pkg.sv
package isa_pkg;

    // word and index widths
    localparam int word_w = 32;
    localparam int reg_idx_w = 4;

    typedef logic [word_w-1:0] word_t;
    typedef logic [word_w-1:0] instr_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // register file and pc
    localparam int num_regs = 15;
    localparam reg_idx_t pc_reg = 4'd15;
    localparam word_t pc_step = 32'd4;
    // r15 reads two instructions ahead
    localparam word_t pc_read_offset = 32'd8;

    //////////////////////////////////////////////////////////////////////
    // instruction field positions
    localparam int op_msb = 27;
    localparam int op_lsb = 26;
    localparam int i_bit = 25;
    localparam int cmd_msb = 24;
    localparam int cmd_lsb = 21;
    localparam int rn_msb = 19;
    localparam int rn_lsb = 16;
    localparam int rd_msb = 15;
    localparam int rd_lsb = 12;
    localparam int shamt_msb = 11;
    localparam int shamt_lsb = 7;
    localparam int sh_msb = 6;
    localparam int sh_lsb = 5;
    // set for register-specified shift amounts
    localparam int shreg_bit = 4;
    localparam int rm_msb = 3;
    localparam int rm_lsb = 0;
    localparam int imm8_msb = 7;
    localparam int imm24_msb = 23;

    //////////////////////////////////////////////////////////////////////
    // encodings
    typedef enum logic [1:0] {
        op_dp     = 2'b00,
        op_branch = 2'b10
    } op_e;

    typedef enum logic [3:0] {
        alu_and = 4'b0000,
        alu_sub = 4'b0010,
        alu_add = 4'b0100,
        alu_orr = 4'b1100
    } alu_op_e;

    typedef enum logic [1:0] {
        sh_lsl = 2'b00,
        sh_lsr = 2'b01,
        sh_asr = 2'b10,
        sh_ror = 2'b11
    } shift_e;

endpackage
